// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Mdir obj_dir
TOP       = cpuTb
FILELIST  = list.f

SRCS := $(shell grep -v '^+' $(FILELIST)) sim/cpuTests.svh
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+sim
verilog/cpuPkg.sv
verilog/instDecode.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/nextPc.sv
verilog/addrGen.sv
verilog/singleCycleCpu.sv
sim/cpuTb.sv

// ==== sim/cpuTests.svh ====
// x1 and x2 hold the operands and x3 the result
function automatic cpuPkg::word_t regRegOp(logic [6:0] f7, logic [2:0] f3);
    return rType(f7, 5'd2, 5'd1, f3, 5'd3, cpuPkg::opOp);
endfunction

function automatic cpuPkg::word_t regImmOp(cpuPkg::word_t imm, logic [2:0] f3);
    return iType(imm, 5'd1, f3, 5'd3, cpuPkg::opOpImm);
endfunction

task automatic aluCase(cpuPkg::word_t inst, cpuPkg::word_t expVal);
    emit(inst);
    storeExpect(5'd3, 32'h100 + cpuPkg::word_t'(expAddr.size() * 4), expVal);
endtask

task automatic arithTest();
    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t imm;
    logic [11:0]   raw;
    logic [4:0]    sh;
    a = $urandom();
    b = $urandom();
    raw = 12'($urandom());
    imm = {{20{raw[11]}}, raw};
    sh = 5'($urandom());
    newProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b000), a + b);
    aluCase(regRegOp(cpuPkg::funct7Alt, 3'b000), a - b);  // sub
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b001), a << b[4:0]);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b010), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b011), (a < b) ? 32'd1 : 32'd0);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b100), a ^ b);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b101), a >> b[4:0]);
    aluCase(regRegOp(cpuPkg::funct7Alt, 3'b101), cpuPkg::word_t'($signed(a) >>> b[4:0]));
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b110), a | b);
    aluCase(regRegOp(cpuPkg::funct7Base, 3'b111), a & b);
    aluCase(regImmOp(imm, 3'b000), a + imm);
    aluCase(regImmOp(imm, 3'b010), ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0);
    aluCase(regImmOp(imm, 3'b011), (a < imm) ? 32'd1 : 32'd0);  // imm sign-extended first
    aluCase(regImmOp(imm, 3'b100), a ^ imm);
    aluCase(regImmOp(imm, 3'b110), a | imm);
    aluCase(regImmOp(imm, 3'b111), a & imm);
    aluCase(regImmOp({27'd0, sh}, 3'b001), a << sh);
    aluCase(regImmOp({27'd0, sh}, 3'b101), a >> sh);
    aluCase(regImmOp({20'd0, 7'b0100000, sh}, 3'b101), cpuPkg::word_t'($signed(a) >>> sh));
    endProgram();
    runProgram();
    compareStores();
endtask

task automatic loadUseTest();
    cpuPkg::word_t p;
    cpuPkg::word_t q;
    p = $urandom();
    q = $urandom();
    newProgram();
    dataMem[32'h200] = p;
    dataMem[32'h204] = q;
    emit(iType(32'h200, 5'd0, cpuPkg::memWordFunct, 5'd1, cpuPkg::opLoad));
    emit(iType(32'h204, 5'd0, cpuPkg::memWordFunct, 5'd2, cpuPkg::opLoad));
    emit(regRegOp(cpuPkg::funct7Base, 3'b000));
    storeExpect(5'd3, 32'h300, p + q);
    loadConst(5'd4, 32'h200);  // base register plus offset
    emit(iType(32'h4, 5'd4, cpuPkg::memWordFunct, 5'd5, cpuPkg::opLoad));
    emit(rType(cpuPkg::funct7Base, 5'd5, 5'd1, 3'b100, 5'd6, cpuPkg::opOp));
    storeExpect(5'd6, 32'h304, p ^ q);
    emit(iType(32'd123, 5'd0, 3'b000, 5'd0, cpuPkg::opOpImm));  // write to x0
    storeExpect(5'd0, 32'h308, 32'd0);
    endProgram();
    runProgram();
    compareStores();
endtask

task automatic branchCase(logic [2:0] f3, cpuPkg::regAddr_t ra, cpuPkg::regAddr_t rb,
        logic taken);
    emit(bType(32'd8, rb, ra, f3));
    if (taken) begin
        skipInst(nop());
    end else begin
        emit(nop());
    end
endtask

task automatic controlTest();
    cpuPkg::word_t link;
    cpuPkg::word_t target;
    newProgram();
    loadConst(5'd1, 32'hffff_fffb);  // -5 is large when unsigned
    loadConst(5'd2, 32'd7);
    branchCase(3'b000, 5'd1, 5'd1, 1'b1);
    branchCase(3'b000, 5'd1, 5'd2, 1'b0);
    branchCase(3'b001, 5'd1, 5'd2, 1'b1);
    branchCase(3'b001, 5'd2, 5'd2, 1'b0);
    branchCase(3'b100, 5'd1, 5'd2, 1'b1);
    branchCase(3'b100, 5'd2, 5'd1, 1'b0);
    branchCase(3'b101, 5'd2, 5'd1, 1'b1);
    branchCase(3'b101, 5'd1, 5'd2, 1'b0);
    branchCase(3'b110, 5'd2, 5'd1, 1'b1);
    branchCase(3'b110, 5'd1, 5'd2, 1'b0);
    branchCase(3'b111, 5'd1, 5'd2, 1'b1);
    branchCase(3'b111, 5'd2, 5'd1, 1'b0);
    link = pcNow();
    emit(jType(32'd12, 5'd5));
    skipInst(nop());
    skipInst(nop());
    storeExpect(5'd5, 32'h400, link + 32'd4);
    target = pcNow() + 32'd16;  // after lui, addi, jalr and one skipped word
    loadConst(5'd6, target + 32'd1);  // odd target whose bit 0 must be dropped
    link = pcNow();
    emit(iType(32'd0, 5'd6, 3'b000, 5'd7, cpuPkg::opJalr));
    skipInst(nop());
    storeExpect(5'd7, 32'h404, link + 32'd4);
    endProgram();
    runProgram();
    matchPcTrace();
    compareStores();
endtask

task automatic upperImmTest();
    logic [19:0]   u;
    cpuPkg::word_t auipcPc;
    u = 20'($urandom());
    newProgram();
    emit(uType(u, 5'd1, cpuPkg::opLui));
    storeExpect(5'd1, 32'h500, {u, 12'd0});
    auipcPc = pcNow();
    emit(uType(u, 5'd2, cpuPkg::opAuipc));
    storeExpect(5'd2, 32'h504, auipcPc + {u, 12'd0});
    endProgram();
    runProgram();
    compareStores();
endtask

task automatic haltCase(cpuPkg::word_t bad);
    newProgram();
    emit(nop());
    emit(bad);  // sits at address 4
    runProgram();
    checkWord("instAddr", instAddr, 32'd4);
    repeat (5) begin
        @(negedge clk);
        #2;
        checkWord("instAddr", instAddr, 32'd4);
        checkBit("halt", halt, 1'b1);
    end
    if (storeAddrLog.size() != 0) begin
        reportProblem("a store was written by a halted CPU");
    end
endtask

task automatic haltTest();
    haltCase(32'h0000_000b);
    haltCase(iType(32'd0, 5'd0, 3'b000, 5'd1, cpuPkg::opLoad));  // lb
    haltCase(sType(32'd2, 5'd0, 5'd0, cpuPkg::memWordFunct));
    haltCase(bType(32'd8, 5'd0, 5'd0, 3'b010));
    haltCase(rType(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, cpuPkg::opOp));
endtask

// the store at address 0 is presented during reset and must wait for release
task automatic resetTest();
    newProgram();
    storeExpect(5'd0, 32'h600, 32'd0);
    endProgram();
    runProgram();
    compareStores();
endtask

// ==== sim/cpuTb.sv ====
module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic          clk;
    logic          rst;
    cpuPkg::word_t instAddr;
    cpuPkg::word_t instWord;
    cpuPkg::word_t dataAddr;
    cpuPkg::word_t dataWrData;
    logic          dataWen;
    cpuPkg::word_t dataRdData;
    logic          halt;

    cpuPkg::word_t prog [$];  // program image from address 0
    cpuPkg::word_t dataMem [cpuPkg::word_t];
    cpuPkg::word_t storeAddrLog [$];
    cpuPkg::word_t storeDataLog [$];
    cpuPkg::word_t pcTrace [$];  // instAddr at each falling edge out of reset
    cpuPkg::word_t expTrace [$];
    cpuPkg::word_t expAddr [$];
    cpuPkg::word_t expData [$];
    int errors = 0;
    int checks = 0;
    int budget = 0;  // cycles granted to the tests so far
    int cyclesRun = 0;

    singleCycleCpu DUT (
        .clk(clk), .rst(rst), .instAddr(instAddr), .instWord(instWord),
        .dataAddr(dataAddr), .dataWrData(dataWrData), .dataWen(dataWen),
        .dataRdData(dataRdData), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic cpuPkg::word_t fetchWord(cpuPkg::word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < prog.size()) begin
            return prog[idx];
        end
        return {addr[31:7] ^ 25'(addr[6:0]), 7'b1111111};  // unknown opcode past the program
    endfunction

    function automatic cpuPkg::word_t readData(cpuPkg::word_t addr);
        if (dataMem.exists(addr)) begin
            return dataMem[addr];
        end
        return addr ^ 32'hc3a5_0f00;  // unwritten words
    endfunction

    // fetch first and load data once dataAddr has settled
    always @(negedge clk) begin
        instWord = fetchWord(instAddr);
        #1;
        dataRdData = readData(dataAddr);
        if (rst) begin
            pcTrace.push_back(instAddr);
        end
    end

    always @(posedge clk) begin
        if (dataWen) begin
            dataMem[dataAddr] = dataWrData;
            storeAddrLog.push_back(dataAddr);
            storeDataLog.push_back(dataWrData);
        end
    end

    task automatic checkWord(string name, cpuPkg::word_t got, cpuPkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reportProblem(string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    function automatic cpuPkg::word_t rType(logic [6:0] f7, cpuPkg::regAddr_t rs2,
            cpuPkg::regAddr_t rs1, logic [2:0] f3, cpuPkg::regAddr_t rd, cpuPkg::opcode_e op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic cpuPkg::word_t iType(cpuPkg::word_t imm, cpuPkg::regAddr_t rs1,
            logic [2:0] f3, cpuPkg::regAddr_t rd, cpuPkg::opcode_e op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic cpuPkg::word_t sType(cpuPkg::word_t imm, cpuPkg::regAddr_t rs2,
            cpuPkg::regAddr_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::word_t bType(cpuPkg::word_t imm, cpuPkg::regAddr_t rs2,
            cpuPkg::regAddr_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::opBranch};
    endfunction

    function automatic cpuPkg::word_t uType(logic [19:0] imm, cpuPkg::regAddr_t rd,
            cpuPkg::opcode_e op);
        return {imm, rd, op};
    endfunction

    function automatic cpuPkg::word_t jType(cpuPkg::word_t imm, cpuPkg::regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpuPkg::opJal};
    endfunction

    function automatic cpuPkg::word_t nop();
        return iType(32'd0, 5'd0, 3'b000, 5'd0, cpuPkg::opOpImm);  // addi x0, x0, 0
    endfunction

    function automatic cpuPkg::word_t pcNow();
        return cpuPkg::word_t'(prog.size() * 4);
    endfunction

    task automatic newProgram();
        prog.delete();
        expTrace.delete();
        expAddr.delete();
        expData.delete();
    endtask

    // instruction that is expected to execute
    task automatic emit(cpuPkg::word_t inst);
        expTrace.push_back(pcNow());
        prog.push_back(inst);
    endtask

    // instruction jumped over
    task automatic skipInst(cpuPkg::word_t inst);
        prog.push_back(inst);
    endtask

    task automatic endProgram();
        emit(32'h0000_000b);  // custom-0 opcode halts the cpu
    endtask

    task automatic loadConst(cpuPkg::regAddr_t rd, cpuPkg::word_t value);
        cpuPkg::word_t upper;
        upper = value + 32'h800;  // addi sign-extends its low twelve bits
        emit(uType(upper[31:12], rd, cpuPkg::opLui));
        emit(iType(value, rd, 3'b000, rd, cpuPkg::opOpImm));
    endtask

    task automatic storeExpect(cpuPkg::regAddr_t src, cpuPkg::word_t addr, cpuPkg::word_t val);
        emit(sType(addr, src, 5'd0, cpuPkg::memWordFunct));
        expAddr.push_back(addr);
        expData.push_back(val);
    endtask

    task automatic resetCpu();
        @(negedge clk);
        rst = 1'b0;
        storeAddrLog.delete();
        storeDataLog.delete();
        pcTrace.delete();
        repeat (2) @(negedge clk);
        checkWord("instAddr", instAddr, 32'd0);
        checkBit("dataWen", dataWen, 1'b0);
        if (storeAddrLog.size() != 0) begin
            reportProblem("a store was written while reset was active");
        end
        rst = 1'b1;
    endtask

    task automatic runProgram();
        budget += prog.size() + 10;
        resetCpu();
        #2;
        while (!halt) begin
            @(negedge clk);
            #2;
        end
    endtask

    task automatic compareStores();
        if (storeAddrLog.size() != expAddr.size()) begin
            reportProblem($sformatf("saw %0d stores, expected %0d",
                storeAddrLog.size(), expAddr.size()));
        end else begin
            foreach (expAddr[i]) begin
                checkWord("dataAddr", storeAddrLog[i], expAddr[i]);
                checkWord("dataWrData", storeDataLog[i], expData[i]);
            end
        end
    endtask

    task automatic matchPcTrace();
        if (pcTrace.size() != expTrace.size()) begin
            reportProblem($sformatf("pc trace has %0d entries, expected %0d",
                pcTrace.size(), expTrace.size()));
        end else begin
            foreach (expTrace[i]) begin
                checkWord("instAddr", pcTrace[i], expTrace[i]);
            end
        end
    endtask

    `include "cpuTests.svh"

    // each test adds its program length plus ten cycles to the budget
    initial begin
        while (cyclesRun <= budget) begin
            @(posedge clk);
            cyclesRun++;
        end
        $display("timeout: tests still running after %0d cycles (%0d ns)",
            cyclesRun, cyclesRun * 100);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst = 1'b0;
        instWord = '0;
        dataRdData = '0;
        void'($urandom(32'h2e6af71b));
        arithTest();
        loadUseTest();
        controlTest();
        upperImmTest();
        haltTest();
        resetTest();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/addrGen.sv ====
module addrGen (
    input  cpuPkg::word_t rs1Data,
    input  cpuPkg::word_t immI,
    input  cpuPkg::word_t immS,
    input  logic          isStore,
    input  logic [2:0]    funct3,
    output cpuPkg::word_t effAddr,
    output logic          misaligned
);

    logic badSize;
    logic badAlign;

    // stores and loads use different immediate layouts
    assign effAddr = rs1Data + (isStore ? immS : immI);

    // byte and halfword widths are not supported
    assign badSize = (funct3 != cpuPkg::memWordFunct);

    // word accesses need the low two address bits clear
    assign badAlign = (effAddr[1:0] != 2'b00);

    assign misaligned = badSize || badAlign;

endmodule

// ==== verilog/aluUnit.sv ====
module aluUnit (
    input  cpuPkg::word_t     opA,
    input  cpuPkg::word_t     opB,
    input  cpuPkg::aluFunct_e funct3,
    input  logic [6:0]        funct7,
    input  logic              isImm,
    output cpuPkg::word_t     result,
    output logic              illegal
);

    cpuPkg::shamt_t shamt;
    logic           baseOk;
    logic           altOk;
    logic           lessSigned;
    logic           lessUnsigned;
    cpuPkg::word_t  sumDiff;
    cpuPkg::word_t  shiftRight;

    assign shamt = opB[4:0];  // only low five bits shift

    // for immediates funct7 is immI[11:5]
    assign baseOk = (funct7 == cpuPkg::funct7Base);
    assign altOk  = (funct7 == cpuPkg::funct7Alt);

    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    // addi never subtracts, its funct7 bits are immediate
    assign sumDiff = (altOk && !isImm) ? (opA - opB) : (opA + opB);

    // alternate bit picks arithmetic shift, also for srai
    assign shiftRight = altOk ? cpuPkg::word_t'($signed(opA) >>> shamt) : (opA >> shamt);

    always_comb begin
        case (funct3)
            cpuPkg::fAddSub: begin
                result = sumDiff;
            end
            cpuPkg::fSll: begin
                result = opA << shamt;
            end
            cpuPkg::fSlt: begin
                result = {{(cpuPkg::xlen-1){1'b0}}, lessSigned};
            end
            cpuPkg::fSltu: begin
                result = {{(cpuPkg::xlen-1){1'b0}}, lessUnsigned};
            end
            cpuPkg::fXor: begin
                result = opA ^ opB;
            end
            cpuPkg::fSr: begin
                result = shiftRight;
            end
            cpuPkg::fOr: begin
                result = opA | opB;
            end
            cpuPkg::fAnd: begin
                result = opA & opB;
            end
        endcase
    end

    // illegal encodings
    always_comb begin
        if (isImm) begin
            // only the shift forms carry a funct7 field
            case (funct3)
                cpuPkg::fSll: begin
                    illegal = !baseOk;
                end
                cpuPkg::fSr: begin
                    illegal = !(baseOk || altOk);
                end
                default: begin
                    illegal = 1'b0;
                end
            endcase
        end else begin
            case (funct3)
                cpuPkg::fAddSub, cpuPkg::fSr: begin
                    illegal = !(baseOk || altOk);  // add/sub, srl/sra
                end
                default: begin
                    illegal = !baseOk;
                end
            endcase
        end
    end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    // data path width
    localparam int xlen = 32;

    // machine word, used for data, addresses and instructions
    typedef logic [xlen-1:0] word_t;

    // register index
    typedef logic [4:0] regAddr_t;

    // shift amount, low five bits of the second operand
    typedef logic [4:0] shamt_t;

    // pc step between sequential instructions
    localparam word_t instBytes = 32'd4;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,  // lw
        opStore  = 7'b0100011,  // sw
        opOpImm  = 7'b0010011,  // register-immediate arithmetic
        opOp     = 7'b0110011,  // register-register arithmetic
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opBranch = 7'b1100011,  // conditional branches
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcode_e;

    // funct3 codes of the arithmetic group
    typedef enum logic [2:0] {
        fAddSub = 3'b000,  // add, addi, sub
        fSll    = 3'b001,
        fSlt    = 3'b010,
        fSltu   = 3'b011,
        fXor    = 3'b100,
        fSr     = 3'b101,  // srl, sra and the immediate forms
        fOr     = 3'b110,
        fAnd    = 3'b111
    } aluFunct_e;

    // funct3 codes of the branch group, 010 and 011 are unused
    typedef enum logic [2:0] {
        bEq  = 3'b000,
        bNe  = 3'b001,
        bLt  = 3'b100,
        bGe  = 3'b101,
        bLtu = 3'b110,
        bGeu = 3'b111
    } branchFunct_e;

    // only legal load and store width
    localparam logic [2:0] memWordFunct = 3'b010;

    // funct7 values for the plain and the alternate operation
    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000;  // sub, sra, srai

endpackage

// ==== verilog/instDecode.sv ====
module instDecode (
    input  cpuPkg::word_t    instWord,
    output cpuPkg::opcode_e  opcode,
    output logic [2:0]       funct3,
    output logic [6:0]       funct7,
    output cpuPkg::regAddr_t rs1,
    output cpuPkg::regAddr_t rs2,
    output cpuPkg::regAddr_t rd,
    output cpuPkg::word_t    immI,
    output cpuPkg::word_t    immS,
    output cpuPkg::word_t    immB,
    output cpuPkg::word_t    immU,
    output cpuPkg::word_t    immJ
);

    // values outside the enum pass through, the top flags them
    assign opcode = cpuPkg::opcode_e'(instWord[6:0]);

    assign rd     = instWord[11:7];
    assign funct3 = instWord[14:12];
    assign rs1    = instWord[19:15];
    assign rs2    = instWord[24:20];
    assign funct7 = instWord[31:25];

    // i-type, loads, jalr and immediate arithmetic
    assign immI = {{20{instWord[31]}}, instWord[31:20]};

    // s-type, offset split around rd field
    assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};

    // b-type, halfword offset
    assign immB = {
        {19{instWord[31]}},
        instWord[31],
        instWord[7],
        instWord[30:25],
        instWord[11:8],
        1'b0
    };

    // u-type, upper twenty bits
    assign immU = {instWord[31:12], 12'b0};

    // j-type, halfword offset with scrambled fields
    assign immJ = {
        {11{instWord[31]}},
        instWord[31],
        instWord[19:12],
        instWord[20],
        instWord[30:21],
        1'b0
    };

endmodule

// ==== verilog/nextPc.sv ====
module nextPc (
    input  cpuPkg::word_t   pc,
    input  cpuPkg::word_t   rs1Data,
    input  cpuPkg::word_t   rs2Data,
    input  cpuPkg::word_t   immI,
    input  cpuPkg::word_t   immB,
    input  cpuPkg::word_t   immJ,
    input  cpuPkg::opcode_e opcode,
    input  logic [2:0]      funct3,
    output cpuPkg::word_t   pcNext,
    output logic            illegalBranch
);

    cpuPkg::branchFunct_e brFunct;
    logic                 taken;
    cpuPkg::word_t        jalrSum;
    cpuPkg::word_t        pcSeq;

    assign brFunct = cpuPkg::branchFunct_e'(funct3);
    assign pcSeq   = pc + cpuPkg::instBytes;
    assign jalrSum = rs1Data + immI;

    // branch condition
    always_comb begin
        case (brFunct)
            cpuPkg::bEq:  taken = (rs1Data == rs2Data);
            cpuPkg::bNe:  taken = (rs1Data != rs2Data);
            cpuPkg::bLt:  taken = ($signed(rs1Data) < $signed(rs2Data));
            cpuPkg::bGe:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            cpuPkg::bLtu: taken = (rs1Data < rs2Data);
            cpuPkg::bGeu: taken = (rs1Data >= rs2Data);
            default:      taken = 1'b0;  // 010 and 011
        endcase
    end

    // unused branch codes
    assign illegalBranch = (funct3 == 3'b010) || (funct3 == 3'b011);

    always_comb begin
        case (opcode)
            cpuPkg::opJal: begin
                pcNext = pc + immJ;
            end
            cpuPkg::opJalr: begin
                pcNext = {jalrSum[31:1], 1'b0};  // absolute target, bit 0 cleared
            end
            cpuPkg::opBranch: begin
                pcNext = taken ? (pc + immB) : pcSeq;
            end
            default: begin
                pcNext = pcSeq;
            end
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
module regFile (
    input  logic             clk,
    input  cpuPkg::regAddr_t rs1,
    input  cpuPkg::regAddr_t rs2,
    input  cpuPkg::regAddr_t rd,
    input  logic             wrEn,
    input  cpuPkg::word_t    wrData,
    output cpuPkg::word_t    rs1Data,
    output cpuPkg::word_t    rs2Data
);

    // x1 to x31, x0 has no storage
    cpuPkg::word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (wrEn && (rd != 5'd0)) begin
            regs[rd] <= wrData;
        end
    end

    // combinational read, x0 reads zero
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== verilog/singleCycleCpu.sv ====
module singleCycleCpu (
    input  logic          clk,
    input  logic          rst,
    output cpuPkg::word_t instAddr,
    input  cpuPkg::word_t instWord,
    output cpuPkg::word_t dataAddr,
    output cpuPkg::word_t dataWrData,
    output logic          dataWen,
    input  cpuPkg::word_t dataRdData,
    output logic          halt
);

    cpuPkg::word_t    pc;
    cpuPkg::word_t    pcNext;
    cpuPkg::opcode_e  opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    cpuPkg::regAddr_t rs1;
    cpuPkg::regAddr_t rs2;
    cpuPkg::regAddr_t rd;
    cpuPkg::word_t    immI;
    cpuPkg::word_t    immS;
    cpuPkg::word_t    immB;
    cpuPkg::word_t    immU;
    cpuPkg::word_t    immJ;
    cpuPkg::word_t    rs1Data;
    cpuPkg::word_t    rs2Data;
    cpuPkg::word_t    aluOpB;
    cpuPkg::word_t    aluResult;
    logic             isImm;
    logic             illegalAlu;
    logic             illegalBranch;
    logic             misaligned;
    cpuPkg::word_t    wrData;
    logic             writesRd;
    logic             regWen;

    // pc register, frozen while halted
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
        end else if (!halt) begin
            pc <= pcNext;
        end
    end

    assign instAddr = pc;

    instDecode decode (
        .instWord(instWord), .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
    );

    regFile regs (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .wrEn(regWen), .wrData(wrData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign isImm  = (opcode == cpuPkg::opOpImm);
    assign aluOpB = isImm ? immI : rs2Data;

    aluUnit alu (
        .opA(rs1Data), .opB(aluOpB), .funct3(cpuPkg::aluFunct_e'(funct3)),
        .funct7(funct7), .isImm(isImm), .result(aluResult), .illegal(illegalAlu)
    );

    nextPc pcSel (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .immI(immI), .immB(immB),
        .immJ(immJ), .opcode(opcode), .funct3(funct3), .pcNext(pcNext),
        .illegalBranch(illegalBranch)
    );

    addrGen agen (
        .rs1Data(rs1Data), .immI(immI), .immS(immS), .isStore(opcode == cpuPkg::opStore),
        .funct3(funct3), .effAddr(dataAddr), .misaligned(misaligned)
    );

    assign dataWrData = rs2Data;  // word stores only

    // halt cause by opcode, unknown opcodes halt
    always_comb begin
        case (opcode)
            cpuPkg::opLoad, cpuPkg::opStore: halt = misaligned;
            cpuPkg::opOpImm, cpuPkg::opOp:   halt = illegalAlu;
            cpuPkg::opBranch:                halt = illegalBranch;
            cpuPkg::opJalr:                  halt = (funct3 != 3'b000);
            cpuPkg::opJal, cpuPkg::opLui, cpuPkg::opAuipc: halt = 1'b0;
            default:                         halt = 1'b1;
        endcase
    end

    // writeback select
    always_comb begin
        writesRd = 1'b1;
        case (opcode)
            cpuPkg::opOp, cpuPkg::opOpImm: wrData = aluResult;
            cpuPkg::opLui:                 wrData = immU;
            cpuPkg::opAuipc:               wrData = pc + immU;
            cpuPkg::opJal, cpuPkg::opJalr: wrData = pc + cpuPkg::instBytes;  // link
            cpuPkg::opLoad:                wrData = dataRdData;
            default: begin
                wrData   = '0;
                writesRd = 1'b0;  // stores, branches
            end
        endcase
    end

    assign regWen  = writesRd && !halt && rst;
    assign dataWen = (opcode == cpuPkg::opStore) && !halt && rst;

endmodule
